/* Bender.yml */
package:
  name: trace_debugger

sources:
  # encoder rtl, package first
  - include_dirs:
      - rtl
    files:
      - rtl/trdb_pkg.sv
      - rtl/trdb_stage_if.sv
      - rtl/trdb_stage_pipe.sv
      - rtl/trdb_itype_detector.sv
      - rtl/trdb_branch_map.sv
      - rtl/trdb_priority.sv
      - rtl/trdb_packet_emitter.sv
      - rtl/trace_debugger.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_trace_debugger.sv

/* bench/tb_clock_gen.sv */
/*
 * testbench clock and reset source
 * free-running clock, active-low reset held for a few cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned period_ns  = 8,
    parameter int unsigned rst_cycles = 4
) (
    output logic clk_o,
    output logic rst_no
);
    initial begin
        clk_o = 1'b0;
        forever #(period_ns / 2.0) clk_o = ~clk_o;
    end

    // release just after an edge, away from the flops' sampling point
    initial begin
        rst_no = 1'b0;
        repeat (rst_cycles) @(posedge clk_o);
        #2;
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

/* bench/tb_trace_debugger.sv */
/*
 * trace encoder testbench
 * drives instruction streams, predicts each packet and checks the DUT per cycle
 */
`timescale 1ns/1ps
`default_nettype none

`include "trdb_macros.svh"

module tb_trace_debugger;
    import trdb_pkg::*;

    localparam int unsigned period_ns  = 8;
    localparam int unsigned rst_cycles = 4;
    localparam int unsigned bmap_len   = `TRDB_BMAP_LEN;
    // cycles per test, used for the watchdog
    localparam int unsigned idle_len   = 6;
    localparam int unsigned start_len  = 4;
    localparam int unsigned jump_len   = 12;
    localparam int unsigned full_len   = bmap_len + 5;
    localparam int unsigned trap_len   = 8;
    localparam int unsigned stop_len   = 16;
    localparam int unsigned drain_len  = 8;
    localparam int unsigned stim_len   = idle_len + start_len + jump_len + full_len
                                         + trap_len + stop_len + drain_len;
    localparam int unsigned timeout_ns = (stim_len + rst_cycles + 40) * period_ns;

    // rv32 encodings
    localparam logic [31:0] inst_nop  = 32'h00000013;
    localparam logic [31:0] inst_beq  = 32'h00000063;  // beq x0, x0
    localparam logic [31:0] inst_jalr = 32'h00008067;  // jalr x0, 0(x1)
    localparam logic [31:0] inst_mret = 32'h30200073;

    // test ids
    localparam logic [3:0] t_idle  = 4'd1;
    localparam logic [3:0] t_start = 4'd2;
    localparam logic [3:0] t_jump  = 4'd3;
    localparam logic [3:0] t_full  = 4'd4;
    localparam logic [3:0] t_trap  = 4'd5;
    localparam logic [3:0] t_stop  = 4'd6;

    // packet kinds
    localparam logic [2:0] k_start   = 3'd0;
    localparam logic [2:0] k_trap    = 3'd1;
    localparam logic [2:0] k_addr    = 3'd2;
    localparam logic [2:0] k_map_adr = 3'd3;
    localparam logic [2:0] k_map     = 3'd4;

    typedef struct packed {
        logic        valid;
        logic        qualified;
        logic        exception;
        logic        interrupt;
        logic [4:0]  cause;
        logic [1:0]  priv;
        logic [31:0] pc;
        logic [31:0] inst;
    } rec_t;

    typedef struct packed {
        logic [31:0] due;
        logic [3:0]  test_id;
        logic [2:0]  kind;
        logic [1:0]  ptype;
        logic [3:0]  plen;
        logic [71:0] payload;
    } exp_pkt_t;

    logic        clk;
    logic        rst_n;
    logic        trace_enable;
    logic        inst_valid;
    logic        iretired;
    logic        exception;
    logic        interrupt;
    logic [4:0]  cause;
    logic [1:0]  priv_lvl;
    logic [31:0] inst_data;
    logic [31:0] pc;
    logic        packet_valid;
    logic [1:0]  packet_type;
    logic [3:0]  packet_length;
    logic [71:0] packet_payload;

    // model state, shadow of the three stages and the branch map
    rec_t        m_nc;
    rec_t        m_tc;
    rec_t        m_lc;
    logic [30:0] m_map;
    logic [4:0]  m_count;
    logic [71:0] pl_acc;
    int          pl_pos;
    exp_pkt_t    exp_q[$];
    exp_pkt_t    exp_cur;

    integer      seed;
    int          edge_cnt;
    int          error_count;
    int          kind_seen[5];
    logic [31:0] cur_pc;
    logic [1:0]  cur_priv;
    logic        cur_en;
    logic [3:0]  cur_test;

    tb_clock_gen #(
        .period_ns  (period_ns),
        .rst_cycles (rst_cycles)
    ) u_tb_clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    trace_debugger u_trace_debugger (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .trace_enable_i   (trace_enable),
        .inst_valid_i     (inst_valid),
        .iretired_i       (iretired),
        .exception_i      (exception),
        .interrupt_i      (interrupt),
        .cause_i          (cause),
        .priv_lvl_i       (priv_lvl),
        .inst_data_i      (inst_data),
        .pc_i             (pc),
        .packet_valid_o   (packet_valid),
        .packet_type_o    (packet_type),
        .packet_length_o  (packet_length),
        .packet_payload_o (packet_payload)
    );

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    function automatic string test_name(input logic [3:0] id);
        case (id)
            t_idle:  return "reset_idle";
            t_start: return "trace_start";
            t_jump:  return "uninferable_jump";
            t_full:  return "full_map";
            t_trap:  return "trap";
            t_stop:  return "priv_change_stop";
            default: return "unknown";
        endcase
    endfunction

    function automatic string kind_name(input int k);
        case (k)
            0:       return "format 3 start";
            1:       return "format 3 trap";
            2:       return "format 2";
            3:       return "format 1 with address";
            default: return "format 1 without address";
        endcase
    endfunction

    // jalr, mret and sret that really jumped
    function automatic logic uninferable(input rec_t r);
        return r.valid && !r.exception
               && (r.inst[6:0] == 7'b1100111 || r.inst == 32'h30200073
                   || r.inst == 32'h10200073);
    endfunction

    function automatic logic [31:0] rand_target();
        logic [31:0] r;
        r = $random(seed);
        return (r & 32'h000f_fff0) | 32'h0001_0000;
    endfunction

    // append a field above the ones already packed
    task automatic push_field(input logic [31:0] val, input int width);
        logic [71:0] mask;
        mask   = (72'd1 << width) - 72'd1;
        pl_acc = pl_acc | ((72'(val) & mask) << pl_pos);
        pl_pos = pl_pos + width;
    endtask

    // new instruction enters; the previous one is judged as tc
    task automatic model_step(input rec_t rec);
        logic        br;
        logic        taken;
        logic [30:0] map_c;
        logic [4:0]  cnt_c;
        logic        emit;
        exp_pkt_t    pkt;
        m_lc   = m_tc;
        m_tc   = m_nc;
        m_nc   = rec;
        br     = m_tc.valid && (m_tc.inst[6:0] == 7'b1100011);
        taken  = br && m_nc.valid && (m_nc.pc != m_tc.pc + 32'd4);
        map_c  = m_map;
        cnt_c  = m_count;
        emit   = 1'b0;
        pkt    = '0;
        pl_acc = '0;
        pl_pos = 0;
        if (m_tc.valid && m_tc.qualified && br && m_count != 5'd31) begin
            map_c[m_count] = !taken;
            cnt_c          = m_count + 5'd1;
        end
        if (m_tc.valid && m_tc.qualified && !m_tc.exception) begin
            if (m_lc.valid && m_lc.exception) begin
                emit     = 1'b1;
                pkt.kind = k_trap;
                pkt.plen = 4'd6;
                push_field(32'd3, 2);
                push_field(32'd1, 2);
                push_field(32'(!(br && taken)), 1);
                push_field(32'(m_tc.priv), 2);
                push_field(32'(m_lc.cause), 5);
                push_field(32'(m_lc.interrupt), 1);
                push_field(m_tc.pc, 32);
            end else if (!m_lc.qualified || m_lc.priv != m_tc.priv) begin
                emit     = 1'b1;
                pkt.kind = k_start;
                pkt.plen = 4'd5;
                push_field(32'd3, 2);
                push_field(32'd0, 2);
                push_field(32'(!(br && taken)), 1);
                push_field(32'(m_tc.priv), 2);
                push_field(m_tc.pc, 32);
            end else if (uninferable(m_lc) || !m_nc.qualified) begin
                emit = 1'b1;
                if (cnt_c == 5'd0) begin
                    pkt.kind = k_addr;
                    pkt.plen = 4'd5;
                    push_field(32'd2, 2);
                    push_field(m_tc.pc, 32);
                end else begin
                    pkt.kind = k_map_adr;
                    pkt.plen = 4'd9;
                    push_field(32'd1, 2);
                    push_field(32'(cnt_c), 5);
                    push_field(32'(map_c), 31);
                    push_field(m_tc.pc, 32);
                end
            end else if (cnt_c == 5'd31) begin
                emit     = 1'b1;
                pkt.kind = k_map;
                pkt.plen = 4'd5;
                push_field(32'd1, 2);
                push_field(32'(cnt_c), 5);
                push_field(32'(map_c), 31);
            end
        end
        if (emit) begin
            pkt.ptype   = (pkt.kind <= k_trap) ? 2'd3 : ((pkt.kind == k_addr) ? 2'd2 : 2'd1);
            pkt.due     = 32'(edge_cnt + 2);
            pkt.test_id = cur_test;
            pkt.payload = pl_acc;
            exp_q.push_back(pkt);
            m_map   = '0;
            m_count = '0;
        end else begin
            m_map   = map_c;
            m_count = cnt_c;
        end
    endtask

    task automatic issue(input logic [31:0] inst, input logic exc, input logic irq,
                         input logic [4:0] cs);
        rec_t rec;
        @(posedge clk);
        #1;
        trace_enable  = cur_en;
        inst_valid    = 1'b1;
        iretired      = 1'b1;
        exception     = exc;
        interrupt     = irq;
        cause         = cs;
        priv_lvl      = cur_priv;
        inst_data     = inst;
        pc            = cur_pc;
        rec.valid     = 1'b1;
        rec.qualified = cur_en;
        rec.exception = exc;
        rec.interrupt = irq;
        rec.cause     = cs;
        rec.priv      = cur_priv;
        rec.pc        = cur_pc;
        rec.inst      = inst;
        model_step(rec);
    endtask

    task automatic stream_nops(input int n);
        repeat (n) begin
            issue(inst_nop, 1'b0, 1'b0, 5'd0);
            cur_pc = cur_pc + 32'd4;
        end
    endtask

    // outcome random, taken target never the fall-through
    task automatic random_branch();
        logic [31:0] r;
        logic [31:0] offs;
        r    = $random(seed);
        offs = (r & 32'h3c) + 32'h8;
        issue(inst_beq, 1'b0, 1'b0, 5'd0);
        cur_pc = r[8] ? cur_pc + offs : cur_pc + 32'd4;
    endtask

    // always jumps forward
    task automatic taken_branch();
        issue(inst_beq, 1'b0, 1'b0, 5'd0);
        cur_pc = cur_pc + 32'h10;
    endtask

    task automatic jump_to(input logic [31:0] target);
        issue(inst_jalr, 1'b0, 1'b0, 5'd0);
        cur_pc = target;
    endtask

    task automatic take_trap(input logic [31:0] handler, input logic [1:0] hpriv);
        logic [31:0] r;
        r = $random(seed);
        issue(inst_nop, 1'b1, r[5], r[4:0]);
        cur_pc   = handler;
        cur_priv = hpriv;
    endtask

    task automatic return_from_trap(input logic [31:0] target, input logic [1:0] tpriv);
        issue(inst_mret, 1'b0, 1'b0, 5'd0);
        cur_pc   = target;
        cur_priv = tpriv;
    endtask

    // compare against the packet due at this edge, else expect silence
    always @(negedge clk) begin
        if (exp_q.size() > 0 && exp_q[0].due == 32'(edge_cnt)) begin
            exp_cur = exp_q.pop_front();
            kind_seen[exp_cur.kind] = kind_seen[exp_cur.kind] + 1;
            assert (packet_valid === 1'b1) else begin
                error_count++;
                $display("ERROR %s: packet_valid_o expected 1 actual %b",
                         test_name(exp_cur.test_id), packet_valid);
            end
            assert (packet_type === exp_cur.ptype) else begin
                error_count++;
                $display("ERROR %s: packet_type_o expected %0d actual %0d",
                         test_name(exp_cur.test_id), exp_cur.ptype, packet_type);
            end
            assert (packet_length === exp_cur.plen) else begin
                error_count++;
                $display("ERROR %s: packet_length_o expected %0d actual %0d",
                         test_name(exp_cur.test_id), exp_cur.plen, packet_length);
            end
            assert (packet_payload === exp_cur.payload) else begin
                error_count++;
                $display("ERROR %s: packet_payload_o expected %h actual %h",
                         test_name(exp_cur.test_id), exp_cur.payload, packet_payload);
            end
        end else begin
            assert (packet_valid !== 1'b1) else begin
                error_count++;
                $display("ERROR %s: packet_valid_o expected 0 actual %b at edge %0d",
                         test_name(cur_test), packet_valid, edge_cnt);
            end
        end
    end

    initial begin
        #(timeout_ns);
        $display("watchdog: run did not finish within %0d ns, errors: %0d",
                 timeout_ns, error_count);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        seed         = 32'h8a8bdf12;
        edge_cnt     = 0;
        error_count  = 0;
        kind_seen    = '{default: 0};
        m_nc         = '0;
        m_tc         = '0;
        m_lc         = '0;
        m_map        = '0;
        m_count      = '0;
        trace_enable = 1'b0;
        inst_valid   = 1'b0;
        iretired     = 1'b0;
        exception    = 1'b0;
        interrupt    = 1'b0;
        cause        = '0;
        priv_lvl     = '0;
        inst_data    = '0;
        pc           = '0;
        cur_pc       = 32'h0000_1000;
        cur_priv     = 2'd0;
        cur_en       = 1'b0;
        cur_test     = t_idle;
        @(posedge rst_n);

        // instructions flow but nothing is traced
        stream_nops(idle_len);

        cur_test = t_start;
        cur_en   = 1'b1;
        stream_nops(start_len);

        // empty map first, then with branches pending
        cur_test = t_jump;
        stream_nops(3);
        jump_to(rand_target());
        stream_nops(2);
        repeat (3) random_branch();
        jump_to(rand_target());
        stream_nops(2);

        // overflow, then a jump that must start from an empty map
        cur_test = t_full;
        repeat (bmap_len) random_branch();
        stream_nops(2);
        jump_to(rand_target());
        stream_nops(2);

        cur_test = t_trap;
        stream_nops(2);
        repeat (2) random_branch();
        take_trap(32'h0000_0100, 2'd3);
        stream_nops(3);

        // back to supervisor mode on a taken branch, stop with branches,
        // restart, stop clean
        cur_test = t_stop;
        return_from_trap(rand_target(), 2'd1);
        taken_branch();
        random_branch();
        stream_nops(2);
        cur_en = 1'b0;
        stream_nops(4);
        cur_en = 1'b1;
        stream_nops(3);
        cur_en = 1'b0;
        stream_nops(4);

        stream_nops(drain_len);

        assert (exp_q.size() == 0) else begin
            error_count++;
            $display("%0d expected packets were never checked", exp_q.size());
        end
        for (int k = 0; k < 5; k++) begin
            assert (kind_seen[k] > 0) else begin
                error_count++;
                $display("no %s packet was produced by the stimulus", kind_name(k));
            end
        end
        $display("packets checked: %0d %0d %0d %0d %0d, errors: %0d", kind_seen[0],
                 kind_seen[1], kind_seen[2], kind_seen[3], kind_seen[4], error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/trdb_pkg.sv
rtl/trdb_stage_if.sv
rtl/trdb_stage_pipe.sv
rtl/trdb_itype_detector.sv
rtl/trdb_branch_map.sv
rtl/trdb_priority.sv
rtl/trdb_packet_emitter.sv
rtl/trace_debugger.sv
bench/tb_clock_gen.sv
bench/tb_trace_debugger.sv

/* rtl/trace_debugger.sv */
/*
 * trace encoder top
 * connects the sampling pipeline, detector, branch map, priority and emitter
 */
`timescale 1ns/1ps
`default_nettype none

`include "trdb_macros.svh"

module trace_debugger (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          trace_enable_i,
    input  logic                          inst_valid_i,
    input  logic                          iretired_i,
    input  logic                          exception_i,
    input  logic                          interrupt_i,
    input  logic [`TRDB_CAUSE_LEN-1:0]    cause_i,
    input  logic [`TRDB_PRIV_LEN-1:0]     priv_lvl_i,
    input  logic [`TRDB_XLEN-1:0]         inst_data_i,
    input  logic [`TRDB_XLEN-1:0]         pc_i,
    output logic                          packet_valid_o,
    output trdb_pkg::trdb_format_e        packet_type_o,
    output logic [`TRDB_PLEN_LEN-1:0]     packet_length_o,
    output logic [`TRDB_PAYLOAD_LEN-1:0]  packet_payload_o
);
    import trdb_pkg::*;

    // map state towards priority and emitter
    logic [`TRDB_BMAP_LEN-1:0] branch_map;
    logic [`TRDB_BCNT_LEN-1:0] branch_count;
    logic                      map_empty;
    logic                      map_full;
    // decision also flushes the map
    trdb_decision_t            decision;

    trdb_stage_if stage_if ();

    trdb_stage_pipe i_trdb_stage_pipe (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .trace_enable_i (trace_enable_i),
        .inst_valid_i   (inst_valid_i),
        .iretired_i     (iretired_i),
        .exception_i    (exception_i),
        .interrupt_i    (interrupt_i),
        .cause_i        (cause_i),
        .priv_lvl_i     (priv_lvl_i),
        .inst_data_i    (inst_data_i),
        .pc_i           (pc_i),
        .stage_io       (stage_if.pipe)
    );

    trdb_itype_detector i_trdb_itype_detector (
        .stage_io (stage_if.detect)
    );

    trdb_branch_map i_trdb_branch_map (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .stage_io (stage_if.map),
        .flush_i  (decision),
        .map_o    (branch_map),
        .count_o  (branch_count),
        .empty_o  (map_empty),
        .full_o   (map_full)
    );

    trdb_priority i_trdb_priority (
        .stage_io   (stage_if.prio),
        .empty_i    (map_empty),
        .full_i     (map_full),
        .decision_o (decision)
    );

    trdb_packet_emitter i_trdb_packet_emitter (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .stage_io         (stage_if.emit),
        .decision_i       (decision),
        .map_i            (branch_map),
        .count_i          (branch_count),
        .packet_valid_o   (packet_valid_o),
        .packet_type_o    (packet_type_o),
        .packet_length_o  (packet_length_o),
        .packet_payload_o (packet_payload_o)
    );

endmodule

`default_nettype wire

/* rtl/trdb_branch_map.sv */
/*
 * branch map
 * collects outcomes of branches not yet reported, cleared on each packet
 */
`timescale 1ns/1ps
`default_nettype none

`include "trdb_macros.svh"

module trdb_branch_map (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    trdb_stage_if.map                  stage_io,
    input  trdb_pkg::trdb_decision_t   flush_i,
    output logic [`TRDB_BMAP_LEN-1:0]  map_o,
    output logic [`TRDB_BCNT_LEN-1:0]  count_o,
    output logic                       empty_o,
    output logic                       full_o
);
    localparam int unsigned bmap_len = `TRDB_BMAP_LEN;
    localparam int unsigned bcnt_len = `TRDB_BCNT_LEN;

    logic [bmap_len-1:0] map_q;
    logic [bcnt_len-1:0] count_q;
    logic                add_branch;

    // only traced branches go in, and never past the last slot
    assign add_branch = stage_io.tc.valid && stage_io.tc.qualified && stage_io.tc_branch
                        && (count_q != bcnt_len'(bmap_len));

    // outputs already hold the tc branch
    always_comb begin
        map_o   = map_q;
        count_o = count_q;
        if (add_branch) begin
            // 1 = not taken
            map_o[count_q] = ~stage_io.tc_taken;
            count_o        = count_q + 1'b1;
        end
    end

    assign empty_o = (count_o == '0);
    assign full_o  = (count_o == bcnt_len'(bmap_len));

    // tc leaves at this edge, keep or drop its entry
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i.emit) begin
            map_q   <= '0;
            count_q <= '0;
        end else begin
            map_q   <= map_o;
            count_q <= count_o;
        end
    end

endmodule

`default_nettype wire

/* rtl/trdb_itype_detector.sv */
/*
 * instruction type detector
 * flags conditional branches, their outcome and uninferable jumps in tc
 */
`timescale 1ns/1ps
`default_nettype none

module trdb_itype_detector (
    trdb_stage_if.detect stage_io
);
    // rv32 encodings
    localparam logic [6:0]  op_branch = 7'b1100011;
    localparam logic [6:0]  op_jalr   = 7'b1100111;
    localparam logic [31:0] inst_mret = 32'h30200073;
    localparam logic [31:0] inst_sret = 32'h10200073;

    logic [6:0] tc_opcode;
    logic       is_jalr;
    logic       is_xret;

    assign tc_opcode = stage_io.tc.inst_data[6:0];

    // conditional branch in tc
    assign stage_io.tc_branch = stage_io.tc.valid && (tc_opcode == op_branch);

    // taken when the next pc is not the fall-through
    // no nc yet counts as not taken
    assign stage_io.tc_taken = stage_io.tc_branch && stage_io.nc.valid
                               && (stage_io.nc.iaddr != stage_io.tc.iaddr + 4);

    assign is_jalr = (tc_opcode == op_jalr);
    assign is_xret = (stage_io.tc.inst_data == inst_mret)
                     || (stage_io.tc.inst_data == inst_sret);

    // target cannot be inferred from the program binary
    // a faulting jump never reaches its target
    assign stage_io.tc_updiscon = stage_io.tc.valid && (is_jalr || is_xret)
                                  && !stage_io.tc.exception;

endmodule

`default_nettype wire

/* rtl/trdb_macros.svh */
/*
 * trace encoder constants
 * field widths of the cpu side and the packet side, branch map limits
 */
`ifndef TRDB_MACROS_SVH
`define TRDB_MACROS_SVH

// cpu side
`define TRDB_XLEN        32
`define TRDB_CAUSE_LEN   5
`define TRDB_PRIV_LEN    2

// branch map, one bit per unreported branch
`define TRDB_BMAP_LEN    31
`define TRDB_BCNT_LEN    5

// packet side
`define TRDB_PAYLOAD_LEN 72
`define TRDB_PLEN_LEN    4

`endif

/* rtl/trdb_packet_emitter.sv */
/*
 * packet emitter
 * packs the payload fields for the chosen format and registers the packet
 */
`timescale 1ns/1ps
`default_nettype none

`include "trdb_macros.svh"

module trdb_packet_emitter (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    trdb_stage_if.emit                    stage_io,
    input  trdb_pkg::trdb_decision_t      decision_i,
    input  logic [`TRDB_BMAP_LEN-1:0]     map_i,
    input  logic [`TRDB_BCNT_LEN-1:0]     count_i,
    output logic                          packet_valid_o,
    output trdb_pkg::trdb_format_e        packet_type_o,
    output logic [`TRDB_PLEN_LEN-1:0]     packet_length_o,
    output logic [`TRDB_PAYLOAD_LEN-1:0]  packet_payload_o
);
    import trdb_pkg::*;

    localparam int unsigned payload_w = `TRDB_PAYLOAD_LEN;
    localparam int unsigned plen_w    = `TRDB_PLEN_LEN;

    logic [payload_w-1:0] payload_d;
    logic [6:0]           nbits;
    logic [plen_w-1:0]    length_d;
    logic                 branch_bit;

    // 0 only when tc itself is a taken branch
    assign branch_bit = ~(stage_io.tc_branch & stage_io.tc_taken);

    // fields from bit 0 upward, rest zero
    always_comb begin
        payload_d = '0;
        nbits     = '0;
        case (decision_i.format)
            F3: begin
                if (decision_i.f3_sub == SF_TRAP) begin
                    payload_d = payload_w'({stage_io.tc.iaddr, stage_io.lc.interrupt,
                                            stage_io.lc.cause, stage_io.tc.priv, branch_bit,
                                            decision_i.f3_sub, decision_i.format});
                    nbits     = 7'd45;
                end else begin
                    payload_d = payload_w'({stage_io.tc.iaddr, stage_io.tc.priv, branch_bit,
                                            decision_i.f3_sub, decision_i.format});
                    nbits     = 7'd39;
                end
            end
            F2: begin
                payload_d = payload_w'({stage_io.tc.iaddr, decision_i.format});
                nbits     = 7'd34;
            end
            default: begin
                // format 1, full map always sent
                if (decision_i.f1_kind == F1_WITH_ADDR) begin
                    payload_d = payload_w'({stage_io.tc.iaddr, map_i, count_i,
                                            decision_i.format});
                    nbits     = 7'd70;
                end else begin
                    payload_d = payload_w'({map_i, count_i, decision_i.format});
                    nbits     = 7'd38;
                end
            end
        endcase
    end

    // round up to whole bytes
    assign length_d = plen_w'((nbits + 7'd7) >> 3);

    // single-cycle strobe
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o <= 1'b0;
        end else begin
            packet_valid_o <= decision_i.emit;
        end
    end

    // hold last packet between strobes
    always_ff @(posedge clk_i) begin
        if (decision_i.emit) begin
            packet_type_o    <= decision_i.format;
            packet_length_o  <= length_d;
            packet_payload_o <= payload_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/trdb_pkg.sv */
/*
 * trace encoder types
 * stage record, packet format encodings and the priority decision
 */
`default_nettype none

`include "trdb_macros.svh"

package trdb_pkg;

    // one retired instruction as seen in a pipeline stage
    typedef struct packed {
        logic                       valid;
        logic                       iretired;
        logic                       exception;
        logic                       interrupt;
        logic [`TRDB_CAUSE_LEN-1:0] cause;
        logic [`TRDB_PRIV_LEN-1:0]  priv;
        logic [`TRDB_XLEN-1:0]      iaddr;
        logic [`TRDB_XLEN-1:0]      inst_data;
        // trace_enable_i taken with the instruction
        logic                       qualified;
    } trdb_inst_t;

    // packet type field
    typedef enum logic [1:0] {
        F1 = 2'h1,  // branch map
        F2 = 2'h2,  // address only
        F3 = 2'h3   // sync
    } trdb_format_e;

    // sync subformat
    typedef enum logic [1:0] {
        SF_START = 2'h0,
        SF_TRAP  = 2'h1
    } trdb_f3_sub_e;

    // format 1 with or without trailing address
    typedef enum logic {
        F1_NO_ADDR   = 1'b0,
        F1_WITH_ADDR = 1'b1
    } trdb_f1_kind_e;

    typedef struct packed {
        logic          emit;
        trdb_format_e  format;
        trdb_f3_sub_e  f3_sub;
        trdb_f1_kind_e f1_kind;
    } trdb_decision_t;

endpackage

`default_nettype wire

/* rtl/trdb_priority.sv */
/*
 * packet priority
 * chooses format and subformat for the tc instruction from lc/nc context
 */
`timescale 1ns/1ps
`default_nettype none

module trdb_priority (
    trdb_stage_if.prio                stage_io,
    input  logic                      empty_i,
    input  logic                      full_i,
    output trdb_pkg::trdb_decision_t  decision_o
);
    import trdb_pkg::*;

    logic tc_reportable;
    logic lc_trap;
    logic first_qualified;
    logic priv_change;
    logic last_qualified;

    // only retired, qualified, non-faulting instructions are reported
    assign tc_reportable = stage_io.tc.valid && stage_io.tc.qualified
                           && stage_io.tc.iretired && !stage_io.tc.exception;

    // tc is the trap handler entry
    assign lc_trap         = stage_io.lc.valid && stage_io.lc.exception;
    assign first_qualified = !stage_io.lc.qualified;
    assign priv_change     = stage_io.lc.priv != stage_io.tc.priv;
    // trace is about to stop
    assign last_qualified  = !stage_io.nc.qualified;

    always_comb begin
        decision_o.emit    = 1'b0;
        decision_o.format  = F2;
        decision_o.f3_sub  = SF_START;
        decision_o.f1_kind = F1_NO_ADDR;
        if (tc_reportable) begin
            if (lc_trap) begin
                decision_o.emit   = 1'b1;
                decision_o.format = F3;
                decision_o.f3_sub = SF_TRAP;
            end else if (first_qualified || priv_change) begin
                decision_o.emit   = 1'b1;
                decision_o.format = F3;
                decision_o.f3_sub = SF_START;
            end else if (stage_io.lc_updiscon || last_qualified) begin
                // address needed, branches ride along if any
                decision_o.emit = 1'b1;
                if (empty_i) begin
                    decision_o.format = F2;
                end else begin
                    decision_o.format  = F1;
                    decision_o.f1_kind = F1_WITH_ADDR;
                end
            end else if (full_i) begin
                // map overflow, no address needed
                decision_o.emit    = 1'b1;
                decision_o.format  = F1;
                decision_o.f1_kind = F1_NO_ADDR;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/trdb_stage_if.sv */
/*
 * stage bundle
 * nc, tc and lc instruction records plus the decoder flags
 */
`timescale 1ns/1ps
`default_nettype none

interface trdb_stage_if ();
    import trdb_pkg::*;

    // records, youngest first
    trdb_inst_t nc;
    trdb_inst_t tc;
    trdb_inst_t lc;

    // decoder flags for tc, updiscon delayed into lc
    logic       tc_branch;
    logic       tc_taken;
    logic       tc_updiscon;
    logic       lc_updiscon;

    modport pipe   (output nc, tc, lc, lc_updiscon, input tc_updiscon);
    modport detect (output tc_branch, tc_taken, tc_updiscon, input nc, tc);
    modport prio   (input nc, tc, lc, lc_updiscon);
    // emitter needs the taken flag for the sync branch field
    modport emit   (input tc, lc, tc_branch, tc_taken);
    modport map    (input tc, tc_branch, tc_taken);

endinterface

`default_nettype wire

/* rtl/trdb_stage_pipe.sv */
/*
 * sampling pipeline
 * cpu inputs become the nc record, then shift into tc and lc
 */
`timescale 1ns/1ps
`default_nettype none

`include "trdb_macros.svh"

module trdb_stage_pipe (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       trace_enable_i,
    input  logic                       inst_valid_i,
    input  logic                       iretired_i,
    input  logic                       exception_i,
    input  logic                       interrupt_i,
    input  logic [`TRDB_CAUSE_LEN-1:0] cause_i,
    input  logic [`TRDB_PRIV_LEN-1:0]  priv_lvl_i,
    input  logic [`TRDB_XLEN-1:0]      inst_data_i,
    input  logic [`TRDB_XLEN-1:0]      pc_i,
    trdb_stage_if.pipe                 stage_io
);
    import trdb_pkg::*;

    trdb_inst_t nc_d;

    // pack the cpu signals into one record
    assign nc_d = '{
        valid:     inst_valid_i,
        iretired:  iretired_i,
        exception: exception_i,
        interrupt: interrupt_i,
        cause:     cause_i,
        priv:      priv_lvl_i,
        iaddr:     pc_i,
        inst_data: inst_data_i,
        qualified: trace_enable_i
    };

    // one stage per cycle, no stall
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stage_io.nc          <= '0;
            stage_io.tc          <= '0;
            stage_io.lc          <= '0;
            stage_io.lc_updiscon <= 1'b0;
        end else begin
            stage_io.nc          <= nc_d;
            stage_io.tc          <= stage_io.nc;
            stage_io.lc          <= stage_io.tc;
            // jump flag follows its instruction into lc
            stage_io.lc_updiscon <= stage_io.tc_updiscon;
        end
    end

endmodule

`default_nettype wire
